// ==== compile.f ====
+incdir+rtl
rtl/rbk_rf_pkg.sv
rtl/rbk_rf_cmd_fifo.sv
rtl/rbk_rf_wr_seq.sv
rtl/rbk_rf_rd_seq.sv
rtl/rbk_rf_status.sv
rtl/rbk_rf_ctrl.sv
tests/rbk_rf_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run for the rubik register-file controller

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= rbk_rf_ctrl_tb
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/rbk_rf_ctrl_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// rubik register-file controller testbench
// random surfaces through both sequencers, checked against reference rules
////////////////////////////////////////////////////////////////////////////

`include "rbk_rf_macros.svh"

module rbk_rf_ctrl_tb;

  import rbk_rf_pkg::*;

  localparam int CMD_TMO  = 5000;
  localparam int IDLE_TMO = 20000;
  localparam int ATOM     = `RBK_ATOM_BYTES;

  logic        nvdla_core_clk;
  logic        nvdla_core_rstn;
  rbk_cfg_t    cfg;
  logic        wr_cmd_vld;
  rbk_wr_cmd_t wr_cmd;
  logic        wr_cmd_rdy;
  logic        rd_cmd_vld;
  rbk_rd_cmd_t rd_cmd;
  logic        rd_cmd_rdy;
  logic        data_vld = 1'b0;
  rbk_data_t   data = '0;
  logic        data_rdy;
  logic        wr_vld;
  rbk_wr_req_t wr_req;
  logic        wr_rdy = 1'b0;
  logic        rd_vld;
  rbk_rd_req_t rd_req;
  logic        rd_rdy = 1'b0;

  logic [31:0] seed_data  = 32'h4d1e_52b3;  // payloads and surface sizes
  logic [31:0] seed_stall = 32'h4d1e_52b3;  // ready/valid stalls
  logic        stall_en   = 1'b0;
  logic        wr_fire    = 1'b0;
  int          fail_cnt   = 0;
  int          wr_surf    = 0;
  int          rd_surf    = 0;
  int          wr_done_cnt = 0;
  int          rd_done_cnt = 0;

  rbk_wr_req_t exp_wr_q [$];
  rbk_rd_req_t exp_rd_q [$];
  rbk_data_t   data_q [$];

  rbk_rf_ctrl DUT (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #2 nvdla_core_clk = ~nvdla_core_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random numbers
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int pick(input int lo, input int hi);
    seed_data = xorshift32(seed_data);
    return lo + int'(seed_data % 32'(hi - lo + 1));
  endfunction

  function automatic rbk_data_t rand_beat();
    rbk_data_t d;
    for (int w = 0; w < 16; w++) begin
      seed_data = xorshift32(seed_data);
      d[w*32 +: 32] = seed_data;
    end
    return d;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference rules
  function automatic int wr_beats(input int cols);
    return (cols + 1) / 2;  // two atoms per entry
  endfunction

  function automatic int rd_beats(input rbk_cfg_t c, input int cols);
    if (c.mode == mode_contract) return (cols + 1) / 2;
    if (c.prec == prec_int8) return 1;
    return (cols > 32) ? 2 : 1;
  endfunction

  function automatic rbk_addr_t exp_wr_addr(input rbk_cfg_t c, input int row, input int beat,
                                            input int bpr);
    if (c.mode == mode_contract) return rbk_addr_t'(4 * row + beat);
    return rbk_addr_t'((row * bpr + beat) % 32);
  endfunction

  function automatic rbk_addr_t exp_rd_addr(input rbk_cfg_t c, input int row, input int beat,
                                            input int bpr);
    if (c.mode == mode_contract) return rbk_addr_t'(4 * row + beat);
    if (c.prec != prec_int8) return rbk_addr_t'(2 * row + beat);  // int16 rows span two
    return rbk_addr_t'((row * bpr + beat) % 32);
  endfunction

  function automatic rbk_rd_mask_t exp_rd_mask(input rbk_cfg_t c, input int cols, input int beat);
    int bytes;
    int rem;
    int a0;
    int a1;
    if (c.mode == mode_contract) begin
      a0 = ATOM;
      a1 = (cols - 2 * beat == 1) ? 0 : ATOM;  // odd atom count leaves atom 1 empty
    end else begin
      bytes = (c.prec == prec_int8) ? cols : 2 * cols;
      rem   = bytes - 2 * ATOM * beat;
      if (rem >= 2 * ATOM) begin
        a0 = ATOM;
        a1 = ATOM;
      end else if (rem >= ATOM) begin
        a0 = ATOM;
        a1 = rem - ATOM;
      end else begin
        a0 = rem;
        a1 = 0;
      end
    end
    return {6'(a1), 6'(a0)};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks and stops
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string what, input logic [511:0] exp_v, input logic [511:0] got_v);
    if (exp_v !== got_v) begin
      fail_cnt++;
      $display("ERR %0t: %s mismatch, expected %0h, got %0h", $time, what, exp_v, got_v);
      $display("Checks failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic set_cfg(input rbk_mode_e m, input rbk_prec_e p);
    @(posedge nvdla_core_clk);
    cfg <= '{mode: m, prec: p};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // surface stimulus
  task automatic queue_write(input int rows, input int cols);
    rbk_wr_req_t e;
    rbk_wr_cmd_t c;
    int bpr;
    int n;
    bpr = wr_beats(cols);
    @(negedge nvdla_core_clk);
    for (int r = 0; r < rows; r++) begin
      for (int b = 0; b < bpr; b++) begin
        e.data = rand_beat();
        e.addr = exp_wr_addr(cfg, r, b, bpr);
        e.done = (r == rows - 1) && (b == bpr - 1);
        exp_wr_q.push_back(e);
        data_q.push_back(e.data);
      end
    end
    c.rows = 5'(rows - 1);
    c.cols = 6'(cols - 1);
    wr_surf++;
    @(posedge nvdla_core_clk);
    wr_cmd_vld <= 1'b1;
    wr_cmd     <= c;
    n = 0;
    @(negedge nvdla_core_clk);
    while (!wr_cmd_rdy) begin
      n++;
      if (n > CMD_TMO) stop_run("timeout: write command queue never became ready");
      @(negedge nvdla_core_clk);
    end
    @(posedge nvdla_core_clk);
    wr_cmd_vld <= 1'b0;
  endtask

  task automatic queue_read(input int rows, input int cols);
    rbk_rd_req_t e;
    rbk_rd_cmd_t c;
    int bpr;
    int n;
    bpr = rd_beats(cfg, cols);
    @(negedge nvdla_core_clk);
    for (int r = 0; r < rows; r++) begin
      for (int b = 0; b < bpr; b++) begin
        e.addr = exp_rd_addr(cfg, r, b, bpr);
        e.mask = exp_rd_mask(cfg, cols, b);
        e.done = (r == rows - 1) && (b == bpr - 1);
        exp_rd_q.push_back(e);
      end
    end
    c.rows = 6'(rows - 1);
    c.cols = 6'(cols - 1);
    rd_surf++;
    @(posedge nvdla_core_clk);
    rd_cmd_vld <= 1'b1;
    rd_cmd     <= c;
    n = 0;
    @(negedge nvdla_core_clk);
    while (!rd_cmd_rdy) begin
      n++;
      if (n > CMD_TMO) stop_run("timeout: read command queue never became ready");
      @(negedge nvdla_core_clk);
    end
    @(posedge nvdla_core_clk);
    rd_cmd_vld <= 1'b0;
  endtask

  task automatic wait_idle(input string what, input bit wr_only);
    int n;
    n = 0;
    @(negedge nvdla_core_clk);
    while (exp_wr_q.size() != 0 || data_q.size() != 0 || (!wr_only && exp_rd_q.size() != 0)) begin
      n++;
      if (n > IDLE_TMO) stop_run({"timeout: ", what, " never completed"});
      @(negedge nvdla_core_clk);
    end
    repeat (2) @(posedge nvdla_core_clk);  // status settles a clock after done
  endtask

  // the file must not move while a surface slot is missing
  task automatic watch_stall(input bit on_write, input int cycles);
    int n;
    n = 0;
    @(negedge nvdla_core_clk);
    while (on_write && !data_vld) begin
      n++;
      if (n > CMD_TMO) stop_run("timeout: write data was never offered");
      @(negedge nvdla_core_clk);
    end
    repeat (cycles) begin
      if (on_write && data_vld) begin
        check_eq("data_rdy with both surfaces full", '0, 512'(data_rdy));
      end else if (!on_write && rd_rdy) begin
        check_eq("rd_vld with no surface written", '0, 512'(rd_vld));
      end
      @(negedge nvdla_core_clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stall and data driver
  always @(posedge nvdla_core_clk) begin : drive_stream
    logic [31:0] r;
    seed_stall = xorshift32(seed_stall);
    r = seed_stall;
    wr_rdy <= stall_en ? (r[1:0] != 2'b00) : 1'b1;
    rd_rdy <= stall_en ? (r[3:2] != 2'b00) : 1'b1;
    if (wr_fire) data_q.delete(0);
    if (wr_fire || !data_vld) begin  // an offered beat holds until taken
      if (data_q.size() != 0 && (!stall_en || r[5:4] != 2'b00)) begin
        data_vld <= 1'b1;
        data     <= data_q[0];
      end else begin
        data_vld <= 1'b0;
      end
    end
  end

  // compare, sampled half a cycle before the transfer edge
  always @(negedge nvdla_core_clk) begin : compare
    rbk_wr_req_t ew;
    rbk_rd_req_t er;
    wr_fire = wr_vld;
    if (wr_vld) begin
      if (exp_wr_q.size() == 0) begin
        stop_run("write beat granted with no beat expected");
      end else begin
        ew = exp_wr_q.pop_front();
        check_eq("write address", 512'(ew.addr), 512'(wr_req.addr));
        check_eq("write data", ew.data, wr_req.data);
        check_eq("write done", 512'(ew.done), 512'(wr_req.done));
        if (wr_req.done) wr_done_cnt++;
      end
    end
    if (rd_vld) begin
      if (exp_rd_q.size() == 0) begin
        stop_run("read beat granted with no beat expected");
      end else begin
        er = exp_rd_q.pop_front();
        check_eq("read address", 512'(er.addr), 512'(rd_req.addr));
        check_eq("read mask", 512'(er.mask), 512'(rd_req.mask));
        check_eq("read done", 512'(er.done), 512'(rd_req.done));
        if (rd_req.done) rd_done_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  initial begin : main_seq
    int rows;
    int dims_r [3];
    int dims_c [3];
    nvdla_core_rstn = 1'b0;
    cfg        = '{mode: mode_contract, prec: prec_int8};
    wr_cmd_vld = 1'b0;
    wr_cmd     = '0;
    rd_cmd_vld = 1'b0;
    rd_cmd     = '0;
    repeat (3) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    @(negedge nvdla_core_clk);
    check_eq("wr_vld after reset", '0, 512'(wr_vld));
    check_eq("rd_vld after reset", '0, 512'(rd_vld));
    check_eq("data_rdy after reset", '0, 512'(data_rdy));
    check_eq("wr_cmd_rdy after reset", 512'(1), 512'(wr_cmd_rdy));
    check_eq("rd_cmd_rdy after reset", 512'(1), 512'(rd_cmd_rdy));

    // read issued first, nothing to read yet
    dims_r[0] = pick(1, 8);
    dims_c[0] = pick(1, 8);
    queue_read(dims_r[0], dims_c[0]);
    watch_stall(1'b0, 16);
    queue_write(dims_r[0], dims_c[0]);
    wait_idle("first contract surface", 1'b0);

    // contract surfaces back to back under random stalls
    @(negedge nvdla_core_clk);
    stall_en = 1'b1;
    repeat (6) begin
      rows = pick(1, 8);
      dims_c[0] = pick(1, 8);
      queue_write(rows, dims_c[0]);
      queue_read(rows, dims_c[0]);
    end
    wait_idle("contract surfaces", 1'b0);

    set_cfg(mode_split, prec_int8);
    repeat (4) begin
      rows = pick(1, 16);
      queue_write(rows, pick(1, 8));
      queue_read(rows, pick(1, 64));
    end
    wait_idle("split int8 surfaces", 1'b0);

    set_cfg(mode_split, prec_int16);
    for (int k = 0; k < 4; k++) begin
      rows = pick(1, 16);
      queue_write(rows, pick(1, 8));
      queue_read(rows, (k % 2 == 0) ? pick(33, 64) : pick(1, 32));  // two beats, then one
    end
    wait_idle("split int16 surfaces", 1'b0);

    // two surfaces written and unread, the third write has to wait
    @(negedge nvdla_core_clk);
    stall_en = 1'b0;
    set_cfg(mode_contract, prec_int8);
    for (int k = 0; k < 3; k++) begin
      dims_r[k] = pick(1, 8);
      dims_c[k] = pick(1, 8);
    end
    queue_write(dims_r[0], dims_c[0]);
    queue_write(dims_r[1], dims_c[1]);
    wait_idle("two unread surfaces", 1'b1);
    queue_write(dims_r[2], dims_c[2]);
    watch_stall(1'b1, 16);
    for (int k = 0; k < 3; k++) begin
      queue_read(dims_r[k], dims_c[k]);
    end
    wait_idle("full file drain", 1'b0);

    check_eq("write surfaces done", 512'(wr_surf), 512'(wr_done_cnt));
    check_eq("read surfaces done", 512'(rd_surf), 512'(rd_done_cnt));
    if (fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== rtl/rbk_rf_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// rubik register-file controller, top level
// command queues, write and read sequencers and surface status
////////////////////////////////////////////////////////////////////////////

module rbk_rf_ctrl (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  rbk_rf_pkg::rbk_cfg_t    cfg,
  input  logic                    wr_cmd_vld,
  input  rbk_rf_pkg::rbk_wr_cmd_t wr_cmd,
  output logic                    wr_cmd_rdy,
  input  logic                    rd_cmd_vld,
  input  rbk_rf_pkg::rbk_rd_cmd_t rd_cmd,
  output logic                    rd_cmd_rdy,
  input  logic                    data_vld,
  input  rbk_rf_pkg::rbk_data_t   data,
  output logic                    data_rdy,
  output logic                    wr_vld,
  output rbk_rf_pkg::rbk_wr_req_t wr_req,
  input  logic                    wr_rdy,
  output logic                    rd_vld,
  output rbk_rf_pkg::rbk_rd_req_t rd_req,
  input  logic                    rd_rdy
);

  import rbk_rf_pkg::*;

  localparam int WR_CMD_W = $bits(rbk_wr_cmd_t);
  localparam int RD_CMD_W = $bits(rbk_rd_cmd_t);

  logic                wr_q_vld;
  logic [WR_CMD_W-1:0] wr_q_pd;
  logic                wr_q_pop;
  logic                rd_q_vld;
  logic [RD_CMD_W-1:0] rd_q_pd;
  logic                rd_q_pop;
  logic                rf_full;
  logic                rf_nempty;

  ////////////////////////////////////////////////////////////////////////////
  // command queues
  rbk_rf_cmd_fifo #(.WIDTH(WR_CMD_W)) u_wr_cmd_fifo (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_vld          (wr_cmd_vld),
    .in_pd           (WR_CMD_W'(wr_cmd)),
    .in_rdy          (wr_cmd_rdy),
    .out_vld         (wr_q_vld),
    .out_pd          (wr_q_pd),
    .out_rdy         (wr_q_pop)
  );

  rbk_rf_cmd_fifo #(.WIDTH(RD_CMD_W)) u_rd_cmd_fifo (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_vld          (rd_cmd_vld),
    .in_pd           (RD_CMD_W'(rd_cmd)),
    .in_rdy          (rd_cmd_rdy),
    .out_vld         (rd_q_vld),
    .out_pd          (rd_q_pd),
    .out_rdy         (rd_q_pop)
  );

  ////////////////////////////////////////////////////////////////////////////
  // sequencers and status
  rbk_rf_wr_seq u_wr_seq (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (cfg),
    .cmd_vld         (wr_q_vld),
    .cmd             (rbk_wr_cmd_t'(wr_q_pd)),
    .cmd_pop         (wr_q_pop),
    .data_vld        (data_vld),
    .data            (data),
    .data_rdy        (data_rdy),
    .full            (rf_full),
    .wr_rdy          (wr_rdy),
    .wr_vld          (wr_vld),
    .wr_req          (wr_req)
  );

  rbk_rf_rd_seq u_rd_seq (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (cfg),
    .cmd_vld         (rd_q_vld),
    .cmd             (rbk_rd_cmd_t'(rd_q_pd)),
    .cmd_pop         (rd_q_pop),
    .nempty          (rf_nempty),
    .rd_rdy          (rd_rdy),
    .rd_vld          (rd_vld),
    .rd_req          (rd_req)
  );

  rbk_rf_status u_status (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_done         (wr_vld & wr_req.done),  // done only counts on a granted beat
    .rd_done         (rd_vld & rd_req.done),
    .full            (rf_full),
    .nempty          (rf_nempty)
  );

endmodule

// ==== rtl/rbk_rf_status.sv ====
////////////////////////////////////////////////////////////////////////////
// rubik register-file status
// two-surface write/read pointers with full and not-empty flags
////////////////////////////////////////////////////////////////////////////

module rbk_rf_status (
  input  logic nvdla_core_clk,
  input  logic nvdla_core_rstn,
  input  logic wr_done,
  input  logic rd_done,
  output logic full,
  output logic nempty
);

  logic [1:0] wptr;  // extra msb tells full from empty
  logic [1:0] rptr;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (wr_done) begin
        wptr <= wptr + 2'd1;
      end
      if (rd_done) begin
        rptr <= rptr + 2'd1;
      end
    end
  end

  assign full   = (wptr[1] ^ rptr[1]) & (wptr[0] == rptr[0]);
  assign nempty = (wptr != rptr);

  a_rd_done_empty: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    rd_done |-> (wptr != rptr))
    else $error("surface read completed with the register file empty");

endmodule

// ==== rtl/rbk_rf_rd_seq.sv ====
////////////////////////////////////////////////////////////////////////////
// rubik read sequencer
// pops read commands, drives read addresses and the per-atom byte mask
////////////////////////////////////////////////////////////////////////////

`include "rbk_rf_macros.svh"

module rbk_rf_rd_seq (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  rbk_rf_pkg::rbk_cfg_t    cfg,
  input  logic                    cmd_vld,
  input  rbk_rf_pkg::rbk_rd_cmd_t cmd,
  output logic                    cmd_pop,
  input  logic                    nempty,
  input  logic                    rd_rdy,
  output logic                    rd_vld,
  output rbk_rf_pkg::rbk_rd_req_t rd_req
);

  import rbk_rf_pkg::*;

  localparam logic [5:0] ATOM = 6'(`RBK_ATOM_BYTES);

  logic         pop_hold;
  logic         take;
  logic         open;
  logic [6:0]   tot_col;    // elements in split, atoms in contract
  logic [6:0]   tot_row;
  logic [5:0]   beats_row;
  logic [4:0]   ccnt;
  logic [5:0]   ccnt_inc;
  logic [5:0]   rcnt;
  logic [6:0]   rcnt_inc;
  logic         col_end;
  logic         surf_end;
  logic         m_contract;
  logic         m_int8;
  rbk_addr_t    addr;
  logic [6:0]   remain_col;
  logic [7:0]   byte_num;
  logic [7:0]   remain_byte;
  logic [7:0]   remain_byte1;
  rbk_rd_mask_t contract_mask;
  rbk_rd_mask_t split_mask;

  // reserved mode falls into the split path
  assign m_contract = (cfg.mode == mode_contract);
  assign m_int8     = (cfg.prec == prec_int8);

  ////////////////////////////////////////////////////////////////////////////
  // command pop
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pop_hold <= 1'b1;
    end else if (pop_hold & cmd_vld) begin
      pop_hold <= 1'b0;
    end else if (surf_end & ~cmd_vld) begin
      pop_hold <= 1'b1;
    end
  end

  assign cmd_pop = surf_end | pop_hold;
  assign take    = cmd_vld & cmd_pop;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      tot_col <= '0;
      tot_row <= '0;
      open    <= 1'b0;
    end else begin
      if (take) begin
        tot_col <= {1'b0, cmd.cols} + 7'd1;
        tot_row <= {1'b0, cmd.rows} + 7'd1;
      end
      if (take) begin
        open <= 1'b1;
      end else if (surf_end) begin
        open <= 1'b0;
      end
    end
  end

  always_comb begin
    if (m_contract) begin
      beats_row = tot_col[6:1] + {5'd0, tot_col[0]};
    end else if (m_int8) begin
      beats_row = 6'd1;
    end else begin
      beats_row = (tot_col > 7'd32) ? 6'd2 : 6'd1;  // int16 past 32 columns spills over
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // beat grant, counters and address
  assign rd_vld   = rd_rdy & nempty & open;
  assign ccnt_inc = {1'b0, ccnt} + 6'd1;
  assign rcnt_inc = {1'b0, rcnt} + 7'd1;
  assign col_end  = rd_vld & (ccnt_inc == beats_row);
  assign surf_end = col_end & (rcnt_inc == tot_row);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      ccnt <= '0;
      rcnt <= '0;
      addr <= '0;
    end else begin
      if (col_end) begin
        ccnt <= '0;
      end else if (rd_vld) begin
        ccnt <= ccnt_inc[4:0];
      end
      if (surf_end) begin
        rcnt <= '0;
      end else if (col_end) begin
        rcnt <= rcnt_inc[5:0];
      end
      if (surf_end) begin
        addr <= '0;
      end else if (m_contract & col_end) begin
        addr <= {rcnt_inc[2:0], 2'b00};
      end else if (~m_contract & ~m_int8 & col_end) begin
        addr <= {rcnt_inc[3:0], 1'b0};  // split int16 rows take two entries
      end else if (rd_vld) begin
        addr <= addr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // byte mask with atom 0 in [5:0] and atom 1 in [11:6]
  assign remain_col    = tot_col - {ccnt, 2'b00} + {1'b0, ccnt, 1'b0};
  assign contract_mask = (remain_col == 7'd1) ? {6'd0, ATOM} : {ATOM, ATOM};  // odd tail

  assign byte_num     = m_int8 ? {1'b0, tot_col} : {tot_col, 1'b0};
  assign remain_byte  = byte_num - {ccnt[1:0], 6'd0};
  assign remain_byte1 = remain_byte - 8'd32;

  always_comb begin
    if (remain_byte >= 8'd64) begin
      split_mask = {ATOM, ATOM};
    end else if (remain_byte >= 8'd32) begin
      split_mask = {remain_byte1[5:0], ATOM};
    end else begin
      split_mask = {6'd0, remain_byte[5:0]};
    end
  end

  assign rd_req.done = surf_end;
  assign rd_req.mask = m_contract ? contract_mask : split_mask;
  assign rd_req.addr = addr;

  // the beat count must not shift under a surface in flight
  a_rd_beat_in_surf: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    rd_vld |-> (ccnt_inc <= beats_row) && (rcnt_inc <= tot_row))
    else $error("register-file read granted outside the captured surface");

endmodule

// ==== rtl/rbk_rf_wr_seq.sv ====
////////////////////////////////////////////////////////////////////////////
// rubik write sequencer
// pops write commands, counts beats and drives register-file write addresses
////////////////////////////////////////////////////////////////////////////

module rbk_rf_wr_seq (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  rbk_rf_pkg::rbk_cfg_t    cfg,
  input  logic                    cmd_vld,
  input  rbk_rf_pkg::rbk_wr_cmd_t cmd,
  output logic                    cmd_pop,
  input  logic                    data_vld,
  input  rbk_rf_pkg::rbk_data_t   data,
  output logic                    data_rdy,
  input  logic                    full,
  input  logic                    wr_rdy,
  output logic                    wr_vld,
  output rbk_rf_pkg::rbk_wr_req_t wr_req
);

  import rbk_rf_pkg::*;

  logic      pop_hold;
  logic      take;
  logic      open;
  logic [6:0] cols_p1;
  logic [5:0] rows_p1;
  logic [5:0] beats_row;   // beats per row
  logic [5:0] tot_row;
  logic [4:0] ccnt;
  logic [5:0] ccnt_inc;
  logic [4:0] rcnt;
  logic [5:0] rcnt_inc;
  logic      col_end;
  logic      surf_end;
  logic      m_contract;
  rbk_addr_t addr;

  assign m_contract = (cfg.mode == mode_contract);

  ////////////////////////////////////////////////////////////////////////////
  // command pop
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pop_hold <= 1'b1;
    end else if (pop_hold & cmd_vld) begin
      pop_hold <= 1'b0;
    end else if (surf_end & ~cmd_vld) begin
      pop_hold <= 1'b1;  // idle when nothing is waiting
    end
  end

  assign cmd_pop = surf_end | pop_hold;
  assign take    = cmd_vld & cmd_pop;

  assign cols_p1 = {1'b0, cmd.cols} + 7'd1;
  assign rows_p1 = {1'b0, cmd.rows} + 6'd1;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      beats_row <= '0;
      tot_row   <= '0;
      open      <= 1'b0;
    end else begin
      if (take) begin
        beats_row <= cols_p1[6:1] + {5'd0, cols_p1[0]};  // two atoms per beat
        tot_row   <= rows_p1;
      end
      if (take) begin
        open <= 1'b1;
      end else if (surf_end) begin
        open <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // beat grant and counters
  assign data_rdy = open & wr_rdy & ~full & data_vld;
  assign wr_vld   = data_vld & data_rdy;

  assign ccnt_inc = {1'b0, ccnt} + 6'd1;
  assign rcnt_inc = {1'b0, rcnt} + 6'd1;
  assign col_end  = wr_vld & (ccnt_inc == beats_row);
  assign surf_end = col_end & (rcnt_inc == tot_row);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      ccnt <= '0;
      rcnt <= '0;
      addr <= '0;
    end else begin
      if (col_end) begin
        ccnt <= '0;
      end else if (wr_vld) begin
        ccnt <= ccnt_inc[4:0];
      end
      if (surf_end) begin
        rcnt <= '0;
      end else if (col_end) begin
        rcnt <= rcnt_inc[4:0];
      end
      if (surf_end) begin
        addr <= '0;
      end else if (m_contract & col_end) begin
        addr <= {rcnt_inc[2:0], 2'b00};  // fixed 4-entry row stride
      end else if (wr_vld) begin
        addr <= addr + 1'b1;
      end
    end
  end

  assign wr_req.done = surf_end;
  assign wr_req.addr = addr;
  assign wr_req.data = data;

  // granted beats stay inside the surface captured at the pop
  a_wr_beat_in_surf: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    wr_vld |-> (ccnt_inc <= beats_row) && (rcnt_inc <= tot_row))
    else $error("register-file write granted outside the captured surface");

endmodule

// ==== rtl/rbk_rf_cmd_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// rubik command queue
// small registered valid/ready FIFO holding commands for a sequencer
////////////////////////////////////////////////////////////////////////////

`include "rbk_rf_macros.svh"

module rbk_rf_cmd_fifo #(
  parameter int WIDTH = 11
) (
  input  logic             nvdla_core_clk,
  input  logic             nvdla_core_rstn,
  input  logic             in_vld,
  input  logic [WIDTH-1:0] in_pd,
  output logic             in_rdy,
  output logic             out_vld,
  output logic [WIDTH-1:0] out_pd,
  input  logic             out_rdy
);

  localparam int DEPTH = `RBK_CMD_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_rdy  = (count < CNT_W'(DEPTH));
  assign out_vld = (count != '0);
  assign out_pd  = mem[rd_ptr];
  assign push    = in_vld & in_rdy;
  assign pop     = out_vld & out_rdy;

  always_ff @(posedge nvdla_core_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_pd;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);  // push and pop may coincide
    end
  end

  // a full queue that is not popped keeps its count and its head entry
  a_no_push_full: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (count == CNT_W'(DEPTH)) && !pop |=> (count == CNT_W'(DEPTH)) && $stable(out_pd))
    else $error("command queue accepted a push while full");

endmodule

// ==== rtl/rbk_rf_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// rubik register-file controller
// mode, configuration, command and request types
////////////////////////////////////////////////////////////////////////////

`include "rbk_rf_macros.svh"

package rbk_rf_pkg;

  typedef enum logic [1:0] {
    mode_contract = 2'd0,
    mode_split    = 2'd1,
    mode_reserved = 2'd2
  } rbk_mode_e;

  // anything other than int8 counts as 2-byte
  typedef enum logic [1:0] {
    prec_int8  = 2'd0,
    prec_int16 = 2'd1
  } rbk_prec_e;

  typedef struct packed {
    rbk_mode_e mode;
    rbk_prec_e prec;
  } rbk_cfg_t;

  typedef logic [`RBK_ADDR_W-1:0]   rbk_addr_t;
  typedef logic [`RBK_DATA_W-1:0]   rbk_data_t;
  typedef logic [2*`RBK_MASK_W-1:0] rbk_rd_mask_t;  // [11:6] atom 1, [5:0] atom 0

  // rows and columns both carry value minus one
  typedef struct packed {
    logic [`RBK_WR_ROW_W-1:0] rows;
    logic [`RBK_COL_W-1:0]    cols;
  } rbk_wr_cmd_t;

  typedef struct packed {
    logic [`RBK_RD_ROW_W-1:0] rows;
    logic [`RBK_COL_W-1:0]    cols;
  } rbk_rd_cmd_t;

  typedef struct packed {
    logic      done;  // last beat of the surface
    rbk_addr_t addr;
    rbk_data_t data;
  } rbk_wr_req_t;

  typedef struct packed {
    logic         done;
    rbk_rd_mask_t mask;
    rbk_addr_t    addr;
  } rbk_rd_req_t;

endpackage

// ==== rtl/rbk_rf_macros.svh ====
////////////////////////////////////////////////////////////////////////////
// rubik register-file controller
// widths and constants shared by the package and the RTL
////////////////////////////////////////////////////////////////////////////

`ifndef RBK_RF_MACROS_SVH
`define RBK_RF_MACROS_SVH

// one register-file entry, two atoms wide
`define RBK_DATA_W      512

// entry address into the 32-entry file
`define RBK_ADDR_W      5

// bytes per atom
`define RBK_ATOM_BYTES  32

// entries in each command queue
`define RBK_CMD_DEPTH   2

// row and column fields of the commands (value minus one)
`define RBK_WR_ROW_W    5
`define RBK_RD_ROW_W    6
`define RBK_COL_W       6

// byte counts in the read mask, per atom
`define RBK_MASK_W      6

`endif
